//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ########################################################################
    // Widths and sizes
    // ########################################################################

    localparam int unsigned xlen = 32;

    localparam int unsigned queue_depth = 2;
    localparam int unsigned queue_ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int unsigned queue_cnt_w = $clog2(queue_depth + 1);

    // ########################################################################
    // Major opcodes
    // ########################################################################

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // ########################################################################
    // Operation codes
    // ########################################################################

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b    // Used by lui.
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } br_op_e;

    // Bundle passed from the decoder to execute.
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        br_op_e          br_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic            is_jal;
        logic            is_jalr;
        logic            gpr_we;      // Already cleared for rd of x0.
        logic            illegal;
    } decoded_t;

endpackage

`default_nettype wire

//--- design/stage_if.sv
`default_nettype none

// One decoded bundle with a valid/ready handshake.
interface stage_if;

    logic             valid;
    logic             ready;
    rv_pkg::decoded_t bundle;

    modport source (
        output valid,
        output bundle,
        input  ready
    );

    modport sink (
        input  valid,
        input  bundle,
        output ready
    );

endinterface

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic [4:0]              raddr1,
    input  logic [4:0]              raddr2,
    input  logic [4:0]              waddr,
    input  logic                    wen,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2
);

    // No storage behind x0.
    logic [rv_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- design/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [rv_pkg::xlen-1:0] in_pc,
    input  logic [rv_pkg::xlen-1:0] in_inst,
    output logic                    in_ready,
    stage_if.source                 dec_out
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_j;
    rv_pkg::decoded_t       dec;
    rv_pkg::decoded_t       out_bundle;
    logic                   out_valid;

    // Shared funct3 table of the register and immediate ALU forms.
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  op = rv_pkg::alu_sll;
            3'b010:  op = rv_pkg::alu_slt;
            3'b011:  op = rv_pkg::alu_sltu;
            3'b100:  op = rv_pkg::alu_xor;
            3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  op = rv_pkg::alu_or;
            default: op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = in_inst[6:0];
    assign funct3 = in_inst[14:12];
    assign funct7 = in_inst[31:25];

    assign imm_i = {{20{in_inst[31]}}, in_inst[31:20]};
    assign imm_u = {in_inst[31:12], 12'b0};
    assign imm_b = {{20{in_inst[31]}}, in_inst[7], in_inst[30:25], in_inst[11:8], 1'b0};
    assign imm_j = {{12{in_inst[31]}}, in_inst[19:12], in_inst[20], in_inst[30:21], 1'b0};

    // ########################################################################
    // Field decode
    // ########################################################################

    always_comb begin
        dec         = '0;
        dec.pc      = in_pc;
        dec.rs1     = in_inst[19:15];
        dec.rs2     = in_inst[24:20];
        dec.rd      = in_inst[11:7];
        dec.alu_op  = rv_pkg::alu_add;
        dec.br_op   = rv_pkg::br_none;
        dec.gpr_we  = 1'b1;
        dec.illegal = 1'b0;

        case (opcode)
            rv_pkg::op_reg: begin
                dec.alu_op = alu_sel(funct3, in_inst[30]);
                // Bit 30 only for sub and sra.
                if (funct7 != 7'h00 &&
                    !(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    dec.illegal = 1'b1;
                end
            end
            rv_pkg::op_imm: begin
                dec.imm         = imm_i;
                dec.src2_is_imm = 1'b1;
                dec.alu_op      = alu_sel(funct3, funct3 == 3'b101 && in_inst[30]);
                if (funct3 == 3'b001 && funct7 != 7'h00) begin
                    dec.illegal = 1'b1;
                end
                if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20) begin
                    dec.illegal = 1'b1;
                end
            end
            rv_pkg::op_lui: begin
                dec.imm         = imm_u;
                dec.src2_is_imm = 1'b1;
                dec.alu_op      = rv_pkg::alu_pass_b;
            end
            rv_pkg::op_auipc: begin
                dec.imm         = imm_u;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
            end
            rv_pkg::op_jal: begin
                dec.imm         = imm_j;
                dec.src1_is_pc  = 1'b1;    // ALU forms pc+imm.
                dec.src2_is_imm = 1'b1;
                dec.is_jal      = 1'b1;
            end
            rv_pkg::op_jalr: begin
                dec.imm         = imm_i;
                dec.src2_is_imm = 1'b1;
                dec.is_jalr     = 1'b1;
                dec.illegal     = (funct3 != 3'b000);
            end
            rv_pkg::op_branch: begin
                dec.imm    = imm_b;
                dec.gpr_we = 1'b0;
                case (funct3)
                    3'b000:  dec.br_op = rv_pkg::br_beq;
                    3'b001:  dec.br_op = rv_pkg::br_bne;
                    3'b100:  dec.br_op = rv_pkg::br_blt;
                    3'b101:  dec.br_op = rv_pkg::br_bge;
                    3'b110:  dec.br_op = rv_pkg::br_bltu;
                    3'b111:  dec.br_op = rv_pkg::br_bgeu;
                    default: dec.illegal = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;    // Loads, stores, system and the rest.
        endcase

        if (dec.illegal) begin
            dec.gpr_we  = 1'b0;
            dec.br_op   = rv_pkg::br_none;
            dec.is_jal  = 1'b0;
            dec.is_jalr = 1'b0;
        end
        if (dec.rd == 5'd0) begin
            dec.gpr_we = 1'b0;
        end
    end

    // ########################################################################
    // Output register
    // ########################################################################

    assign in_ready = !out_valid || dec_out.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            out_bundle <= dec;
        end
    end

    assign dec_out.valid  = out_valid;
    assign dec_out.bundle = out_bundle;

endmodule

`default_nettype wire

//--- design/decode_queue.sv
`default_nettype none

module decode_queue (
    input  logic  clk,
    input  logic  rst,
    stage_if.sink   q_in,
    stage_if.source q_out
);

    rv_pkg::decoded_t               mem [rv_pkg::queue_depth];
    logic [rv_pkg::queue_ptr_w-1:0] wr_ptr;
    logic [rv_pkg::queue_ptr_w-1:0] rd_ptr;
    logic [rv_pkg::queue_cnt_w-1:0] count;
    logic                           push;
    logic                           pop;

    function automatic logic [rv_pkg::queue_ptr_w-1:0] next_ptr(
        input logic [rv_pkg::queue_ptr_w-1:0] ptr
    );
        return (ptr == rv_pkg::queue_depth - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign q_in.ready   = (count < rv_pkg::queue_depth);
    assign q_out.valid  = (count != '0);
    assign q_out.bundle = mem[rd_ptr];

    assign push = q_in.valid && q_in.ready;
    assign pop  = q_out.valid && q_out.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle, or push and pop together.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= q_in.bundle;
        end
    end

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`default_nettype none

module exec_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ret_ready,
    stage_if.sink                   ex_in,
    output logic                    ret_valid,
    output logic [rv_pkg::xlen-1:0] ret_pc,
    output logic [4:0]              ret_rd,
    output logic                    ret_wen,
    output logic [rv_pkg::xlen-1:0] ret_value,
    output logic                    ret_taken,
    output logic [rv_pkg::xlen-1:0] ret_target,
    output logic                    ret_illegal
);

    rv_pkg::decoded_t        b;
    logic                    accept;
    logic [rv_pkg::xlen-1:0] rs1_val;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [4:0]              shamt;
    logic [rv_pkg::xlen-1:0] alu_res;
    logic [rv_pkg::xlen-1:0] wb_value;
    logic [rv_pkg::xlen-1:0] target;
    logic                    cond;

    assign b            = ex_in.bundle;
    assign ex_in.ready  = !ret_valid || ret_ready;
    assign accept       = ex_in.valid && ex_in.ready;

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (b.rs1),
        .raddr2 (b.rs2),
        .waddr  (b.rd),
        .wen    (accept && b.gpr_we),
        .wdata  (wb_value),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    // ########################################################################
    // ALU and branch compare
    // ########################################################################

    assign op_a  = b.src1_is_pc ? b.pc : rs1_val;
    assign op_b  = b.src2_is_imm ? b.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (b.alu_op)
            rv_pkg::alu_add:  alu_res = op_a + op_b;
            rv_pkg::alu_sub:  alu_res = op_a - op_b;
            rv_pkg::alu_sll:  alu_res = op_a << shamt;
            rv_pkg::alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu: alu_res = {31'b0, op_a < op_b};
            rv_pkg::alu_xor:  alu_res = op_a ^ op_b;
            rv_pkg::alu_srl:  alu_res = op_a >> shamt;
            rv_pkg::alu_sra:  alu_res = $signed(op_a) >>> shamt;
            rv_pkg::alu_or:   alu_res = op_a | op_b;
            rv_pkg::alu_and:  alu_res = op_a & op_b;
            default:          alu_res = op_b;    // Pass for lui.
        endcase
    end

    always_comb begin
        case (b.br_op)
            rv_pkg::br_beq:  cond = (rs1_val == rs2_val);
            rv_pkg::br_bne:  cond = (rs1_val != rs2_val);
            rv_pkg::br_blt:  cond = ($signed(rs1_val) < $signed(rs2_val));
            rv_pkg::br_bge:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            rv_pkg::br_bltu: cond = (rs1_val < rs2_val);
            rv_pkg::br_bgeu: cond = (rs1_val >= rs2_val);
            default:         cond = 1'b0;
        endcase
    end

    always_comb begin
        if (b.is_jal) begin
            target = alu_res;
        end else if (b.is_jalr) begin
            target = {alu_res[rv_pkg::xlen-1:1], 1'b0};
        end else if (b.br_op != rv_pkg::br_none) begin
            target = b.pc + b.imm;
        end else begin
            target = '0;
        end
    end

    // Jumps link pc+4.
    assign wb_value = (b.is_jal || b.is_jalr) ? b.pc + 32'd4 : alu_res;

    // ########################################################################
    // Retire record
    // ########################################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ret_valid <= 1'b0;
        end else if (ex_in.ready) begin
            ret_valid <= ex_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ret_pc      <= b.pc;
            ret_rd      <= b.rd;
            ret_wen     <= b.gpr_we;
            ret_value   <= b.gpr_we ? wb_value : '0;    // Zero when nothing written.
            ret_taken   <= b.is_jal || b.is_jalr || cond;
            ret_target  <= target;
            ret_illegal <= b.illegal;
        end
    end

endmodule

`default_nettype wire

//--- design/rv_slice_top.sv
`default_nettype none

module rv_slice_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic [rv_pkg::xlen-1:0] in_pc,
    input  logic [rv_pkg::xlen-1:0] in_inst,
    output logic                    in_ready,
    input  logic                    ret_ready,
    output logic                    ret_valid,
    output logic [rv_pkg::xlen-1:0] ret_pc,
    output logic [4:0]              ret_rd,
    output logic                    ret_wen,
    output logic [rv_pkg::xlen-1:0] ret_value,
    output logic                    ret_taken,
    output logic [rv_pkg::xlen-1:0] ret_target,
    output logic                    ret_illegal
);

    stage_if dec_to_q ();
    stage_if q_to_ex ();

    inst_decoder u_inst_decoder (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .in_ready (in_ready),
        .dec_out  (dec_to_q.source)
    );

    decode_queue u_decode_queue (
        .clk   (clk),
        .rst   (rst),
        .q_in  (dec_to_q.sink),
        .q_out (q_to_ex.source)
    );

    exec_unit u_exec_unit (
        .clk         (clk),
        .rst         (rst),
        .ret_ready   (ret_ready),
        .ex_in       (q_to_ex.sink),
        .ret_valid   (ret_valid),
        .ret_pc      (ret_pc),
        .ret_rd      (ret_rd),
        .ret_wen     (ret_wen),
        .ret_value   (ret_value),
        .ret_taken   (ret_taken),
        .ret_target  (ret_target),
        .ret_illegal (ret_illegal)
    );

endmodule

`default_nettype wire

//--- bench/tb_rv_slice.sv
`default_nettype none

module tb_rv_slice;

    localparam int max_entries = 64;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_pc;
    logic [31:0] in_inst;
    logic        in_ready;
    logic        ret_ready = 1'b0;
    logic        ret_valid;
    logic [31:0] ret_pc;
    logic [4:0]  ret_rd;
    logic        ret_wen;
    logic [31:0] ret_value;
    logic        ret_taken;
    logic [31:0] ret_target;
    logic        ret_illegal;

    // Stimulus and expected retire records.
    string       t_name    [max_entries];
    logic [31:0] t_inst    [max_entries];
    logic [31:0] t_pc      [max_entries];
    logic [4:0]  t_rd      [max_entries];
    logic        t_wen     [max_entries];
    logic [31:0] t_value   [max_entries];
    logic        t_taken   [max_entries];
    logic        t_ctl     [max_entries];    // Target checked for branches and jumps.
    logic [31:0] t_target  [max_entries];
    logic        t_illegal [max_entries];

    logic [31:0] mirror [32];
    logic [31:0] pc_next;
    logic [31:0] rng_state = 32'd77021;
    int          n_entries;
    int          n_done;
    int          n_pass;
    int          n_fail;
    int          cycle_count;
    int          cycle_limit;
    int          i;

    rv_slice_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_pc       (in_pc),
        .in_inst     (in_inst),
        .in_ready    (in_ready),
        .ret_ready   (ret_ready),
        .ret_valid   (ret_valid),
        .ret_pc      (ret_pc),
        .ret_rd      (ret_rd),
        .ret_wen     (ret_wen),
        .ret_value   (ret_value),
        .ret_taken   (ret_taken),
        .ret_target  (ret_target),
        .ret_illegal (ret_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ########################################################################
    // Encodings and reference model
    // ########################################################################

    function automatic logic [31:0] reg_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [4:0]         sh;
        sa = a;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> sh;    // Sign fill.
                end
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ########################################################################
    // Table construction
    // ########################################################################

    task automatic add_entry(input string name, input logic [31:0] inst, input logic [4:0] rd,
                             input logic wen, input logic [31:0] value, input logic taken,
                             input logic ctl, input logic [31:0] target, input logic illegal);
        t_name[n_entries]    = name;
        t_inst[n_entries]    = inst;
        t_pc[n_entries]      = pc_next;
        t_rd[n_entries]      = rd;
        t_wen[n_entries]     = wen;
        t_value[n_entries]   = value;
        t_taken[n_entries]   = taken;
        t_ctl[n_entries]     = ctl;
        t_target[n_entries]  = target;
        t_illegal[n_entries] = illegal;
        if (wen) begin
            mirror[rd] = value;
        end
        n_entries = n_entries + 1;
        pc_next   = pc_next + 32'd4;
    endtask

    task automatic alu_reg(input string name, input logic [6:0] f7, input logic [2:0] f3,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        add_entry(name, reg_word(f7, rs2, rs1, f3, rd), rd, rd != 5'd0,
                  alu_model(f3, f7[5], mirror[rs1], mirror[rs2]), 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic alu_imm(input string name, input logic [2:0] f3, input logic [11:0] imm,
                           input logic [4:0] rd, input logic [4:0] rs1);
        logic alt;
        alt = (f3 == 3'b101) && imm[10];    // srai only.
        add_entry(name, imm_word(imm, rs1, f3, rd, rv_pkg::op_imm), rd, rd != 5'd0,
                  alu_model(f3, alt, mirror[rs1], {{20{imm[11]}}, imm}),
                  1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic load_upper(input string name, input logic [4:0] rd, input logic [19:0] imm);
        add_entry(name, {imm, rd, rv_pkg::op_lui}, rd, rd != 5'd0, {imm, 12'b0},
                  1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic add_upper_pc(input string name, input logic [4:0] rd, input logic [19:0] imm);
        add_entry(name, {imm, rd, rv_pkg::op_auipc}, rd, rd != 5'd0, pc_next + {imm, 12'b0},
                  1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic jump_link(input string name, input logic [4:0] rd, input logic [20:0] off);
        add_entry(name, jal_word(off, rd), rd, rd != 5'd0, pc_next + 32'd4,
                  1'b1, 1'b1, pc_next + {{11{off[20]}}, off}, 1'b0);
    endtask

    task automatic jump_reg(input string name, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
        logic [31:0] tgt;
        tgt    = mirror[rs1] + {{20{imm[11]}}, imm};
        tgt[0] = 1'b0;
        add_entry(name, imm_word(imm, rs1, 3'b000, rd, rv_pkg::op_jalr), rd, rd != 5'd0,
                  pc_next + 32'd4, 1'b1, 1'b1, tgt, 1'b0);
    endtask

    task automatic branch_case(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [12:0] off);
        logic [31:0] a;
        logic [31:0] b;
        logic        tk;
        a = mirror[rs1];
        b = mirror[rs2];
        case (f3)
            3'b000:  tk = (a == b);
            3'b001:  tk = (a != b);
            3'b100:  tk = ($signed(a) < $signed(b));
            3'b101:  tk = ($signed(a) >= $signed(b));
            3'b110:  tk = (a < b);
            default: tk = (a >= b);
        endcase
        add_entry(name, branch_word(off, rs2, rs1, f3), 5'd0, 1'b0, '0, tk, 1'b1,
                  pc_next + {{19{off[12]}}, off}, 1'b0);
    endtask

    task automatic illegal_case(input string name, input logic [31:0] inst);
        add_entry(name, inst, 5'd0, 1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
    endtask

    task automatic build_table();
        for (int r = 0; r < 32; r++) begin
            mirror[r] = '0;
        end
        n_entries = 0;
        pc_next   = 32'h0000_1000;
        // Register setup.
        alu_imm("addi x1", 3'b000, 12'd100, 5'd1, 5'd0);
        alu_imm("addi x2 neg", 3'b000, -12'sd7, 5'd2, 5'd0);
        load_upper("lui x3", 5'd3, 20'h80000);
        alu_imm("addi x3 dep", 3'b000, 12'h123, 5'd3, 5'd3);
        alu_imm("addi x4", 3'b000, 12'd3, 5'd4, 5'd0);
        // R-type.
        alu_reg("add", 7'h00, 3'b000, 5'd5, 5'd1, 5'd2);
        alu_reg("sub", 7'h20, 3'b000, 5'd6, 5'd1, 5'd2);
        alu_reg("sll", 7'h00, 3'b001, 5'd7, 5'd1, 5'd4);
        alu_reg("slt mixed", 7'h00, 3'b010, 5'd8, 5'd2, 5'd1);
        alu_reg("sltu mixed", 7'h00, 3'b011, 5'd9, 5'd2, 5'd1);
        alu_reg("xor", 7'h00, 3'b100, 5'd10, 5'd1, 5'd2);
        alu_reg("srl neg", 7'h00, 3'b101, 5'd11, 5'd3, 5'd4);
        alu_reg("sra neg", 7'h20, 3'b101, 5'd12, 5'd3, 5'd4);
        alu_reg("or", 7'h00, 3'b110, 5'd13, 5'd1, 5'd2);
        alu_reg("and", 7'h00, 3'b111, 5'd14, 5'd1, 5'd3);
        // I-type.
        alu_imm("slti mixed", 3'b010, 12'd5, 5'd16, 5'd2);
        alu_imm("sltiu mixed", 3'b011, 12'd5, 5'd17, 5'd2);
        alu_imm("xori", 3'b100, 12'hfff, 5'd18, 5'd1);
        alu_imm("ori", 3'b110, 12'h0f0, 5'd19, 5'd1);
        alu_imm("andi", 3'b111, 12'h7ff, 5'd20, 5'd3);
        alu_imm("slli", 3'b001, 12'd4, 5'd21, 5'd1);
        alu_imm("srli neg", 3'b101, 12'd28, 5'd22, 5'd2);
        alu_imm("srai neg", 3'b101, 12'h402, 5'd23, 5'd2);
        // Upper immediates and jumps.
        add_upper_pc("auipc", 5'd24, 20'h12345);
        jump_link("jal fwd", 5'd25, 21'd16);
        jump_link("jal back", 5'd29, -21'sd64);
        jump_reg("jalr odd", 5'd26, 5'd1, 12'd3);
        jump_reg("jalr x0", 5'd0, 5'd25, -12'sd8);
        // Branches taken then not taken.
        branch_case("beq t", 3'b000, 5'd1, 5'd1, 13'd32);
        branch_case("beq nt", 3'b000, 5'd1, 5'd2, 13'd32);
        branch_case("bne t", 3'b001, 5'd1, 5'd2, -13'sd16);
        branch_case("bne nt", 3'b001, 5'd4, 5'd4, 13'd8);
        branch_case("blt t", 3'b100, 5'd2, 5'd1, 13'd12);
        branch_case("blt nt", 3'b100, 5'd1, 5'd2, 13'd12);
        branch_case("bge t", 3'b101, 5'd1, 5'd2, -13'sd4);
        branch_case("bge nt", 3'b101, 5'd2, 5'd1, 13'd20);
        branch_case("bltu t", 3'b110, 5'd1, 5'd2, 13'd64);
        branch_case("bltu nt", 3'b110, 5'd2, 5'd1, 13'd64);
        branch_case("bgeu t", 3'b111, 5'd2, 5'd1, -13'sd128);
        branch_case("bgeu nt", 3'b111, 5'd1, 5'd2, 13'd4);
        // x0 writes.
        alu_imm("addi x0", 3'b000, 12'd5, 5'd0, 5'd1);
        load_upper("lui x0", 5'd0, 20'habcde);
        alu_reg("read x0", 7'h00, 3'b000, 5'd27, 5'd0, 5'd0);
        // Illegal encodings.
        illegal_case("load", imm_word(12'd0, 5'd1, 3'b010, 5'd5, 7'b0000011));
        illegal_case("store", imm_word(12'd8, 5'd1, 3'b010, 5'd2, 7'b0100011));
        illegal_case("ecall", 32'h0000_0073);
        illegal_case("zero word", 32'h0000_0000);
        // Back-to-back dependent chain.
        alu_imm("chain 1", 3'b000, 12'd1, 5'd28, 5'd0);
        alu_reg("chain 2", 7'h00, 3'b000, 5'd28, 5'd28, 5'd28);
        alu_reg("chain 3", 7'h00, 3'b000, 5'd28, 5'd28, 5'd28);
        alu_reg("chain 4", 7'h20, 3'b000, 5'd30, 5'd28, 5'd5);
    endtask

    // ########################################################################
    // Checking
    // ########################################################################

    task automatic compare_field(input string name, input string field, input logic [31:0] exp,
                                 input logic [31:0] act, inout bit bad);
        if (act !== exp) begin
            if (!bad) begin
                $display("FAIL %s: %s expected %h actual %h", name, field, exp, act);
            end
            bad = 1'b1;
        end
    endtask

    task automatic check_record(input int k);
        bit bad;
        bad = 1'b0;
        compare_field(t_name[k], "pc", t_pc[k], ret_pc, bad);
        compare_field(t_name[k], "wen", 32'(t_wen[k]), 32'(ret_wen), bad);
        compare_field(t_name[k], "illegal", 32'(t_illegal[k]), 32'(ret_illegal), bad);
        compare_field(t_name[k], "taken", 32'(t_taken[k]), 32'(ret_taken), bad);
        if (t_wen[k]) begin
            compare_field(t_name[k], "rd", 32'(t_rd[k]), 32'(ret_rd), bad);
            compare_field(t_name[k], "value", t_value[k], ret_value, bad);
        end
        if (t_ctl[k]) begin
            compare_field(t_name[k], "target", t_target[k], ret_target, bad);
        end
        if (bad) begin
            n_fail = n_fail + 1;
        end else begin
            n_pass = n_pass + 1;
            $display("PASS %s", t_name[k]);
        end
    endtask

    // Random retire back-pressure.
    always @(posedge clk) begin
        rng_state = xorshift32(rng_state);
        ret_ready <= (rng_state[1:0] != 2'b00);
    end

    // Record transfers on the next rising edge.
    always @(negedge clk) begin
        if (!rst && ret_valid && ret_ready) begin
            if (n_done >= n_entries) begin
                $display("Extra retire record seen with pc %h.", ret_pc);
                n_fail = n_fail + 1;
            end else begin
                check_record(n_done);
                n_done = n_done + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: records missing");
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_pc       = '0;
        in_inst     = '0;
        n_done      = 0;
        n_pass      = 0;
        n_fail      = 0;
        cycle_count = 0;
        cycle_limit = 0;
        build_table();
        cycle_limit = 8 * n_entries + 50;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (i = 0; i < n_entries; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_pc    <= t_pc[i];
            in_inst  <= t_inst[i];
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        wait (n_done == n_entries);
        repeat (10) @(posedge clk);    // Catch stray records.
        $display("passed %0d, failed %0d, of %0d", n_pass, n_fail, n_entries);
        if (n_fail == 0 && n_pass == n_entries) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_slice.f
design/rv_pkg.sv
design/stage_if.sv
design/reg_file.sv
design/inst_decoder.sv
design/decode_queue.sv
design/exec_unit.sv
design/rv_slice_top.sv
bench/tb_rv_slice.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the RV32I slice testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_rv_slice \
    -f rv_slice.f \
    -o sim_rv_slice

./obj_dir/sim_rv_slice | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "Simulation reported failures."
    exit 1
fi
echo "Simulation finished cleanly."
